// File: Bender.yml
package:
  name: tic

export_include_dirs:
  - include

sources:
  - files:
      - src/tic_pkg.sv
      - src/tic_reg_decode.sv
      - src/tic_timer.sv
      - src/tic_intr_ctrl.sv
      - src/tic_rdata_mux.sv
      - src/tic_top.sv
  - target: test
    files:
      - tests/tic_sva.sv
      - tests/tic_tb.sv

// File: flist.f
+incdir+include
src/tic_pkg.sv
src/tic_reg_decode.sv
src/tic_timer.sv
src/tic_intr_ctrl.sv
src/tic_rdata_mux.sv
src/tic_top.sv
tests/tic_sva.sv
tests/tic_tb.sv

// File: include/tic_macros.svh
// ---------------------------------------------------------------------------
// Widths and register offsets shared by the timer and interrupt block.
// Include this header wherever a bus width, timer width or register offset
// is needed. The package pulls it in for its struct widths.
// ---------------------------------------------------------------------------

`ifndef TIC_MACROS_SVH
`define TIC_MACROS_SVH

// Word address on the register bus
`define TIC_ADDR_W 4

// Bus data width
`define TIC_DATA_W 32

// Byte enables, one per data byte
`define TIC_BE_W (`TIC_DATA_W / 8)

// Timer and compare width
`define TIC_TIMER_W 32

// Register offsets on the word address
`define TIC_OFS_MTIME    0
`define TIC_OFS_ENB      4
`define TIC_OFS_CC       8
`define TIC_OFS_MTIMECMP 12

`endif // TIC_MACROS_SVH

// File: src/tic_intr_ctrl.sv
// ---------------------------------------------------------------------------
// Interrupt gateway for three level sources. Latches the highest-priority
// source as a one-hot id, tracks pending until a claim (CC read) and active
// until a complete (CC write), and gates intr_o with the enable bit, which
// every completion clears.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tic_intr_ctrl
  import tic_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  tic_access_t acc_i,
  // Bit 0 has no source
  input  logic [3:0]  int_src_i,

  output tic_irq_id_e irq_id_o,
  output logic        enb_o,
  output logic        intr_o
);

  tic_irq_id_e irq_id_q;
  logic [3:0]  id_bits;
  logic [3:0]  ip_q;       // pending
  logic [3:0]  ia_q;       // active
  logic [3:0]  claim_q;
  logic [3:0]  complete_q;
  logic        enb_q;
  logic        cc_rd;
  logic        cc_wr;
  logic        enb_wr;
  logic        claim_busy;

  assign cc_rd  = acc_i.rd & (acc_i.sel == REG_CC);
  assign cc_wr  = acc_i.wr & (acc_i.sel == REG_CC);
  assign enb_wr = acc_i.wr & (acc_i.sel == REG_ENB);

  assign id_bits    = irq_id_q;
  assign claim_busy = |claim_q;

  // Id capture, source 3 first, then 2, then 1
  // Frozen while a claim is outstanding, a CC write loads it instead
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_id_q <= IRQ_NONE;
    end else if (int_src_i[3] && !claim_busy) begin
      irq_id_q <= IRQ_TIMER;
    end else if (int_src_i[2] && !claim_busy) begin
      irq_id_q <= IRQ_EXT2;
    end else if (int_src_i[1] && !claim_busy) begin
      irq_id_q <= IRQ_EXT1;
    end else if (cc_wr) begin
      irq_id_q <= tic_irq_id_e'(acc_i.wdata[3:0]);
    end
  end

  // Pending set from the id unless active, cleared by the claim
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ip_q <= '0;
    end else begin
      ip_q <= (ip_q | (id_bits & ~ia_q & ~ip_q)) & ~(ip_q & claim_q);
    end
  end

  // Active blocks a re-raise of the same id until complete
  // Set wins over a complete in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ia_q <= '0;
    end else begin
      ia_q <= (ia_q | (id_bits & ~ia_q)) & ~(ia_q & complete_q & ~ip_q);
    end
  end

  // Claim held from the CC read until the completing write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      claim_q <= '0;
    end else if (cc_wr) begin
      claim_q <= '0;
    end else if (cc_rd && intr_o) begin
      claim_q <= id_bits;
    end
  end

  // One-cycle complete pulse for the current id
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      complete_q <= '0;
    end else begin
      complete_q <= cc_wr ? id_bits : '0;
    end
  end

  // Enable, software write or cleared by any completion
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enb_q <= 1'b0;
    end else if (enb_wr) begin
      enb_q <= acc_i.wdata[0];
    end else if (|complete_q) begin
      enb_q <= 1'b0;
    end
  end

  assign intr_o   = (|ip_q) & enb_q;
  assign irq_id_o = irq_id_q;
  assign enb_o    = enb_q;

endmodule

`default_nettype wire

// File: src/tic_pkg.sv
// ---------------------------------------------------------------------------
// Types for the timer and interrupt block: the raw bus request, the decoded
// register access, the register select and the one-hot interrupt ids.
// Modules take these by a wildcard import in their headers.
// ---------------------------------------------------------------------------

`default_nettype none

`include "tic_macros.svh"

package tic_pkg;

  // Plain register bus, read data comes back in the same cycle
  typedef struct packed {
    logic                   re;
    logic                   we;
    logic [`TIC_BE_W-1:0]   be;
    logic [`TIC_ADDR_W-1:0] addr;
    logic [`TIC_DATA_W-1:0] wdata;
  } tic_bus_req_t;

  // Addressed register, REG_NONE for unmapped addresses
  typedef enum logic [2:0] {
    REG_NONE     = 3'd0,
    REG_MTIME    = 3'd1,
    REG_ENB      = 3'd2,
    REG_CC       = 3'd3,
    REG_MTIMECMP = 3'd4
  } tic_reg_sel_e;

  // Access after decode, strobes already qualified by the select
  typedef struct packed {
    tic_reg_sel_e           sel;
    logic                   rd;
    logic                   wr;
    logic [`TIC_BE_W-1:0]   be;
    logic [`TIC_DATA_W-1:0] wdata;
  } tic_access_t;

  // One-hot ids, bit position is the source number
  typedef enum logic [3:0] {
    IRQ_NONE  = 4'd0,
    IRQ_EXT1  = 4'd2,
    IRQ_EXT2  = 4'd4,
    IRQ_TIMER = 4'd8
  } tic_irq_id_e;

endpackage

`default_nettype wire

// File: src/tic_rdata_mux.sv
// ---------------------------------------------------------------------------
// Read data select. Returns the addressed register during a read, in the
// same cycle as the strobe, and zero when nothing is read.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tic_macros.svh"

module tic_rdata_mux
  import tic_pkg::*;
(
  input  tic_access_t             acc_i,
  input  logic [`TIC_TIMER_W-1:0] mtime_i,
  input  logic [`TIC_TIMER_W-1:0] mtimecmp_i,
  input  tic_irq_id_e             irq_id_i,
  input  logic                    enb_i,
  output logic [`TIC_DATA_W-1:0]  rdata_o
);

  always_comb begin
    rdata_o = '0;
    if (acc_i.rd) begin
      case (acc_i.sel)
        REG_MTIME: begin
          rdata_o = `TIC_DATA_W'(mtime_i);
        end
        REG_ENB: begin
          // Enable in bit 0
          rdata_o = `TIC_DATA_W'(enb_i);
        end
        REG_CC: begin
          // One-hot id in the low nibble
          rdata_o = `TIC_DATA_W'(irq_id_i);
        end
        REG_MTIMECMP: begin
          rdata_o = `TIC_DATA_W'(mtimecmp_i);
        end
        default: begin
          rdata_o = '0;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: src/tic_reg_decode.sv
// ---------------------------------------------------------------------------
// Address decode for the register bus. Turns the read and write strobes and
// the word address into a register select with qualified strobes. Purely
// combinational, feeds the timer, the controller and the read mux.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tic_macros.svh"

module tic_reg_decode
  import tic_pkg::*;
(
  input  tic_bus_req_t req_i,
  output tic_access_t  acc_o
);

  tic_reg_sel_e sel;
  logic         mapped;

  // Address to register select
  always_comb begin
    sel = REG_NONE;
    case (req_i.addr)
      `TIC_ADDR_W'(`TIC_OFS_MTIME): begin
        sel = REG_MTIME;
      end
      `TIC_ADDR_W'(`TIC_OFS_ENB): begin
        sel = REG_ENB;
      end
      `TIC_ADDR_W'(`TIC_OFS_CC): begin
        sel = REG_CC;
      end
      `TIC_ADDR_W'(`TIC_OFS_MTIMECMP): begin
        sel = REG_MTIMECMP;
      end
      default: begin
        sel = REG_NONE;
      end
    endcase
  end

  // Unmapped address kills both strobes
  assign mapped = (sel != REG_NONE);

  assign acc_o.sel   = sel;
  assign acc_o.rd    = req_i.re & mapped;
  assign acc_o.wr    = req_i.we & mapped;

  // Byte enables and data ride along unchanged
  assign acc_o.be    = req_i.be;
  assign acc_o.wdata = req_i.wdata;

endmodule

`default_nettype wire

// File: src/tic_timer.sv
// ---------------------------------------------------------------------------
// Free-running machine timer with a compare register. The timer source is
// a level, high while the count is at or above the compare value. MTIME is
// reloaded by a full write, MTIMECMP is written byte by byte.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tic_macros.svh"

module tic_timer
  import tic_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_ni,

  input  tic_access_t             acc_i,

  output logic [`TIC_TIMER_W-1:0] mtime_o,
  output logic [`TIC_TIMER_W-1:0] mtimecmp_o,
  output logic                    timer_irq_o
);

  logic [`TIC_TIMER_W-1:0] mtime_q;
  logic [`TIC_TIMER_W-1:0] mtimecmp_q;
  logic                    mtime_we;
  logic                    mtimecmp_we;

  assign mtime_we    = acc_i.wr & (acc_i.sel == REG_MTIME);
  assign mtimecmp_we = acc_i.wr & (acc_i.sel == REG_MTIMECMP);

  // Counter, a bus write takes priority over the increment
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtime_q <= '0;
    end else if (mtime_we) begin
      // Full word reload, byte enables not honoured here
      mtime_q <= `TIC_TIMER_W'(acc_i.wdata);
    end else begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  // Compare value, all ones out of reset so the source stays quiet
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mtimecmp_q <= '1;
    end else if (mtimecmp_we) begin
      // Only the enabled bytes change
      for (int b = 0; b < `TIC_BE_W; b++) begin
        if (acc_i.be[b]) begin
          mtimecmp_q[8*b +: 8] <= acc_i.wdata[8*b +: 8];
        end
      end
    end
  end

  // Level source, follows the counter directly
  assign timer_irq_o = (mtime_q >= mtimecmp_q);

  // Values for the read mux
  assign mtime_o    = mtime_q;
  assign mtimecmp_o = mtimecmp_q;

endmodule

`default_nettype wire

// File: src/tic_top.sv
// ---------------------------------------------------------------------------
// Timer and interrupt block, top level. Decodes the register bus, runs the
// timer and the interrupt gateway and returns read data combinationally.
// Timer drives source 3, the two external lines drive sources 2 and 1.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tic_macros.svh"

module tic_top
  import tic_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  input  tic_bus_req_t           req_i,
  output logic [`TIC_DATA_W-1:0] rdata_o,

  // Level inputs for sources 1 and 2
  input  logic [1:0]             ext_irq_i,
  output logic                   intr_o
);

  tic_access_t             acc;
  logic [`TIC_TIMER_W-1:0] mtime;
  logic [`TIC_TIMER_W-1:0] mtimecmp;
  logic                    timer_irq;
  logic [3:0]              int_src;
  tic_irq_id_e             irq_id;
  logic                    enb;

  tic_reg_decode u_decode (
    .req_i (req_i),
    .acc_o (acc)
  );

  tic_timer u_timer (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .acc_i       (acc),
    .mtime_o     (mtime),
    .mtimecmp_o  (mtimecmp),
    .timer_irq_o (timer_irq)
  );

  // Source 0 does not exist
  assign int_src = {timer_irq, ext_irq_i, 1'b0};

  tic_intr_ctrl u_intr_ctrl (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .acc_i     (acc),
    .int_src_i (int_src),
    .irq_id_o  (irq_id),
    .enb_o     (enb),
    .intr_o    (intr_o)
  );

  tic_rdata_mux u_rdata_mux (
    .acc_i      (acc),
    .mtime_i    (mtime),
    .mtimecmp_i (mtimecmp),
    .irq_id_i   (irq_id),
    .enb_i      (enb),
    .rdata_o    (rdata_o)
  );

endmodule

`default_nettype wire

// File: tests/tic_sva.sv
// ---------------------------------------------------------------------------
// Assertions on the interrupt gateway, bound into every tic_intr_ctrl.
// Covers output gating, the shape of the id and the enable clear that
// follows a completion. Failures are counted for the testbench summary.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tic_sva
  import tic_pkg::*;
(
  input logic        clk_i,
  input logic        rst_ni,
  input tic_access_t acc_i,
  input tic_irq_id_e irq_id_i,
  input logic        enb_i,
  input logic        intr_i
);

  int unsigned n_fail = 0;
  logic        enb_wr;
  logic        cc_wr;

  // A software write of ENB overrides the clear
  assign enb_wr = acc_i.wr && (acc_i.sel == REG_ENB);

  // Completing write of the claimed id
  assign cc_wr  = acc_i.wr && (acc_i.sel == REG_CC);

  // Output is gated by the enable bit
  a_intr_gated: assert property (@(posedge clk_i) disable iff (!rst_ni)
    intr_i |-> enb_i)
  else begin
    $error("intr_o high while enable is clear");
    n_fail++;
  end

  // Id is either empty or a single source
  a_id_onehot0: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(irq_id_i))
  else begin
    $error("irq_id is not zero or one-hot: %b", irq_id_i);
    n_fail++;
  end

  // Enable reads clear one cycle after the CC write takes effect
  a_complete_clears_enb: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cc_wr ##1 !enb_wr) |=> !enb_i)
  else begin
    $error("enable still set after a completion");
    n_fail++;
  end

endmodule

bind tic_intr_ctrl tic_sva i_sva (
  .clk_i    (clk_i),
  .rst_ni   (rst_ni),
  .acc_i    (acc_i),
  .irq_id_i (irq_id_o),
  .enb_i    (enb_o),
  .intr_i   (intr_o)
);

`default_nettype wire

// File: tests/tic_tb.sv
// ---------------------------------------------------------------------------
// Table-driven testbench for the timer and interrupt block. Steps through
// reset values, byte writes to the compare register, a timer interrupt,
// priority, completion and enable gating, checking read data and intr_o.
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "tic_macros.svh"

module tic_tb
  import tic_pkg::*;
();

  localparam int CLK_PERIOD  = 10;
  localparam int RST_CYCLES  = 16;
  localparam int MAX_WAIT    = 80;
  localparam int N_STEPS     = 46;
  localparam int WATCHDOG_NS = (RST_CYCLES + N_STEPS * MAX_WAIT) * CLK_PERIOD;

  localparam logic [31:0] LFSR_SEED = 32'd80883;
  // Toggle mask for x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  localparam logic [`TIC_ADDR_W-1:0] A_MTIME = `TIC_ADDR_W'(`TIC_OFS_MTIME);
  localparam logic [`TIC_ADDR_W-1:0] A_ENB   = `TIC_ADDR_W'(`TIC_OFS_ENB);
  localparam logic [`TIC_ADDR_W-1:0] A_CC    = `TIC_ADDR_W'(`TIC_OFS_CC);
  localparam logic [`TIC_ADDR_W-1:0] A_CMP   = `TIC_ADDR_W'(`TIC_OFS_MTIMECMP);

  typedef enum logic [2:0] {
    OP_WRITE, OP_READ, OP_READ_CMP, OP_READ_ID,
    OP_SET_EXT, OP_WAIT_INTR, OP_WAIT_TIMER, OP_INTR_LOW
  } tb_op_e;

  // Random bits fill the data where rmask is set
  typedef struct {
    string                  name;
    tb_op_e                 op;
    logic [`TIC_ADDR_W-1:0] addr;
    logic [`TIC_BE_W-1:0]   be;
    logic [`TIC_DATA_W-1:0] data;
    logic [`TIC_DATA_W-1:0] rmask;
    logic [`TIC_DATA_W-1:0] exp;
  } step_t;

  logic                   clk;
  logic                   rst_n;
  tic_bus_req_t           req;
  logic [1:0]             ext_irq;
  logic [`TIC_DATA_W-1:0] rdata;
  logic                   intr;

  step_t                   steps [N_STEPS];
  int                      n_built;
  int                      n_checks;
  int                      n_errors;
  logic [31:0]             lfsr_state;
  // Expected compare register, follows every write to MTIMECMP
  logic [`TIC_TIMER_W-1:0] cmp_model;

  tic_top i_dut (
    .clk_i     (clk),
    .rst_ni    (rst_n),
    .req_i     (req),
    .rdata_o   (rdata),
    .ext_irq_i (ext_irq),
    .intr_o    (intr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ LFSR_TAPS;
    end
    return out;
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_bit());
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_random(input logic [31:0] base, input logic [31:0] mask);
    logic [31:0] v;
    v = base;
    for (int i = 0; i < 32; i++) begin
      if (mask[i]) begin
        v[i] = lfsr_bit();
      end
    end
    return v;
  endfunction

  // Enabled bytes come from the new data, the rest keep their old value
  function automatic logic [31:0] apply_byte_enables(input logic [31:0] old_v,
                                                     input logic [31:0] new_v,
                                                     input logic [3:0]  be);
    logic [31:0] keep;
    keep = ~{{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    return (old_v & keep) | (new_v & ~keep);
  endfunction

  task automatic add_step(input string name, input tb_op_e op, input logic [3:0] addr,
                          input logic [3:0] be, input logic [31:0] data,
                          input logic [31:0] rmask, input logic [31:0] exp);
    if (n_built < N_STEPS) begin
      steps[n_built] = '{name, op, addr, be, data, rmask, exp};
    end
    n_built++;
  endtask

  task automatic check_rdata(input string name, input logic [`TIC_DATA_W-1:0] exp,
                             input logic [`TIC_DATA_W-1:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_id(input string name, input tic_irq_id_e exp, input tic_irq_id_e act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("FAIL %s: expected %s (%h), actual %s (%h)", name, exp.name(), exp,
               act.name(), act);
    end
  endtask

  // Strobe for one cycle, then one idle cycle
  task automatic bus_write(input logic [3:0] addr, input logic [3:0] be, input logic [31:0] d);
    @(negedge clk);
    req = '{re: 1'b0, we: 1'b1, be: be, addr: addr, wdata: d};
    @(negedge clk);
    req = '0;
  endtask

  // Read data sampled just before the rising edge
  task automatic bus_read(input logic [3:0] addr, output logic [`TIC_DATA_W-1:0] d);
    @(negedge clk);
    req = '{re: 1'b1, we: 1'b0, be: 4'hf, addr: addr, wdata: '0};
    #(CLK_PERIOD / 2 - 1);
    d = rdata;
    @(negedge clk);
    req = '0;
  endtask

  task automatic wait_intr(input string name, input int bound);
    int cycles;
    cycles = 0;
    while (intr !== 1'b1 && cycles < bound) begin
      @(negedge clk);
      cycles++;
    end
    n_checks++;
    if (intr !== 1'b1) begin
      n_errors++;
      $display("ERROR %s: intr_o did not rise within %0d cycles", name, bound);
    end
  endtask

  task automatic hold_intr_low(input string name, input int n);
    logic seen_high;
    seen_high = 1'b0;
    repeat (n) begin
      @(negedge clk);
      if (intr !== 1'b0) begin
        seen_high = 1'b1;
      end
    end
    n_checks++;
    if (seen_high) begin
      n_errors++;
      $display("ERROR %s: intr_o went high during %0d cycles that had to stay low", name, n);
    end
  endtask

  task automatic run_step(input step_t s);
    logic [31:0]            wdata;
    logic [`TIC_DATA_W-1:0] rd;
    case (s.op)
      OP_WRITE: begin
        wdata = fill_random(s.data, s.rmask);
        if (s.addr == A_CMP) begin
          cmp_model = apply_byte_enables(cmp_model, wdata, s.be);
        end
        bus_write(s.addr, s.be, wdata);
      end
      OP_READ: begin
        bus_read(s.addr, rd);
        check_rdata(s.name, s.exp, rd);
      end
      OP_READ_CMP: begin
        bus_read(A_CMP, rd);
        check_rdata(s.name, cmp_model, rd);
      end
      OP_READ_ID: begin
        bus_read(A_CC, rd);
        check_id(s.name, tic_irq_id_e'(s.exp[3:0]), tic_irq_id_e'(rd[3:0]));
      end
      OP_SET_EXT: begin
        @(negedge clk);
        ext_irq = s.data[1:0];
      end
      OP_WAIT_INTR: begin
        wait_intr(s.name, int'(s.data));
      end
      OP_WAIT_TIMER: begin
        // Bound is the compare value plus 4
        wait_intr(s.name, int'(cmp_model) + 4);
      end
      default: begin
        hold_intr_low(s.name, int'(s.data) + rand_bits(3));
      end
    endcase
  endtask

  task automatic build_table();
    // name            op             addr     be    data          rmask         exp
    add_step("rst_enb",       OP_READ,       A_ENB,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("rst_cc",        OP_READ_ID,    A_CC,    4'hf, 32'h0,        32'h0,        32'h0);
    add_step("rst_cmp",       OP_READ_CMP,   A_CMP,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("rst_intr",      OP_INTR_LOW,   A_MTIME, 4'h0, 32'd4,        32'h0,        32'h0);
    // Byte writes keep byte 3 high so the timer stays quiet
    add_step("cmp_b0",        OP_WRITE,      A_CMP,   4'h1, 32'h0,        32'h0000_00ff, 32'h0);
    add_step("cmp_b0_rd",     OP_READ_CMP,   A_CMP,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("cmp_b12",       OP_WRITE,      A_CMP,   4'h6, 32'h0,        32'h00ff_ff00, 32'h0);
    add_step("cmp_b12_rd",    OP_READ_CMP,   A_CMP,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("cmp_b3",        OP_WRITE,      A_CMP,   4'h8, 32'ha500_0000, 32'h00ff_ffff, 32'h0);
    add_step("cmp_b3_rd",     OP_READ_CMP,   A_CMP,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("cmp_none",      OP_WRITE,      A_CMP,   4'h0, 32'h0,        32'hffff_ffff, 32'h0);
    add_step("cmp_none_rd",   OP_READ_CMP,   A_CMP,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("cmp_all",       OP_WRITE,      A_CMP,   4'hf, 32'hffff_ffff, 32'h0,        32'h0);
    add_step("cmp_all_rd",    OP_READ_CMP,   A_CMP,   4'hf, 32'h0,        32'h0,        32'h0);
    // Timer source with a compare value of 32 to 63
    add_step("tmr_mtime",     OP_WRITE,      A_MTIME, 4'hf, 32'h0,        32'h0,        32'h0);
    add_step("tmr_cmp",       OP_WRITE,      A_CMP,   4'hf, 32'h20,       32'h1f,       32'h0);
    add_step("tmr_cmp_rd",    OP_READ_CMP,   A_CMP,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("tmr_enb",       OP_WRITE,      A_ENB,   4'hf, 32'h1,        32'h0,        32'h0);
    add_step("tmr_wait",      OP_WAIT_TIMER, A_CC,    4'h0, 32'h0,        32'h0,        32'h0);
    add_step("tmr_claim",     OP_READ_ID,    A_CC,    4'hf, 32'h0,        32'h0,        32'h8);
    add_step("tmr_claimed",   OP_INTR_LOW,   A_CC,    4'h0, 32'd2,        32'h0,        32'h0);
    add_step("tmr_cmp_off",   OP_WRITE,      A_CMP,   4'hf, 32'hffff_ffff, 32'h0,        32'h0);
    add_step("tmr_complete",  OP_WRITE,      A_CC,    4'hf, 32'h8,        32'h0,        32'h0);
    // Completion clears the enable, the held id pends again
    add_step("cpl_enb_rd",    OP_READ,       A_ENB,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("cpl_low",       OP_INTR_LOW,   A_CC,    4'h0, 32'd4,        32'h0,        32'h0);
    add_step("cpl_reenb",     OP_WRITE,      A_ENB,   4'hf, 32'h1,        32'h0,        32'h0);
    add_step("cpl_wait",      OP_WAIT_INTR,  A_CC,    4'h0, 32'd2,        32'h0,        32'h0);
    add_step("cpl_claim",     OP_READ_ID,    A_CC,    4'hf, 32'h0,        32'h0,        32'h8);
    // Both lines up, source 2 wins
    add_step("pri_ext",       OP_SET_EXT,    A_CC,    4'h0, 32'h3,        32'h0,        32'h0);
    add_step("pri_complete",  OP_WRITE,      A_CC,    4'hf, 32'h8,        32'h0,        32'h0);
    add_step("pri_enb_rd",    OP_READ,       A_ENB,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("gate_low",      OP_INTR_LOW,   A_CC,    4'h0, 32'd4,        32'h0,        32'h0);
    add_step("gate_enb",      OP_WRITE,      A_ENB,   4'hf, 32'h1,        32'h0,        32'h0);
    add_step("gate_wait",     OP_WAIT_INTR,  A_CC,    4'h0, 32'd2,        32'h0,        32'h0);
    add_step("pri_claim2",    OP_READ_ID,    A_CC,    4'hf, 32'h0,        32'h0,        32'h4);
    add_step("pri_drop2",     OP_SET_EXT,    A_CC,    4'h0, 32'h1,        32'h0,        32'h0);
    add_step("pri_complete2", OP_WRITE,      A_CC,    4'hf, 32'h4,        32'h0,        32'h0);
    add_step("pri_enb_rd2",   OP_READ,       A_ENB,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("pri_low2",      OP_INTR_LOW,   A_CC,    4'h0, 32'd3,        32'h0,        32'h0);
    add_step("pri_reenb",     OP_WRITE,      A_ENB,   4'hf, 32'h1,        32'h0,        32'h0);
    add_step("pri_wait1",     OP_WAIT_INTR,  A_CC,    4'h0, 32'd2,        32'h0,        32'h0);
    add_step("pri_claim1",    OP_READ_ID,    A_CC,    4'hf, 32'h0,        32'h0,        32'h2);
    add_step("end_ext_off",   OP_SET_EXT,    A_CC,    4'h0, 32'h0,        32'h0,        32'h0);
    add_step("end_complete",  OP_WRITE,      A_CC,    4'hf, 32'h2,        32'h0,        32'h0);
    add_step("end_enb_rd",    OP_READ,       A_ENB,   4'hf, 32'h0,        32'h0,        32'h0);
    add_step("end_low",       OP_INTR_LOW,   A_CC,    4'h0, 32'd4,        32'h0,        32'h0);
  endtask

  // Watchdog, sized from the table length and the longest wait
  initial begin
    #(WATCHDOG_NS);
    $display("ERROR watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("test failed");
    $finish;
  end

  initial begin
    rst_n      = 1'b0;
    req        = '0;
    ext_irq    = 2'b00;
    lfsr_state = LFSR_SEED;
    cmp_model  = '1;
    n_built    = 0;
    n_checks   = 0;
    n_errors   = 0;
    build_table();
    if (n_built != N_STEPS) begin
      n_errors++;
      $display("ERROR table holds %0d steps instead of %0d", n_built, N_STEPS);
    end
    repeat (RST_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < N_STEPS; i++) begin
      run_step(steps[i]);
    end
    @(negedge clk);
    $display("Summary: %0d checks, %0d errors, %0d assertion errors", n_checks, n_errors,
             i_dut.u_intr_ctrl.i_sva.n_fail);
    if (n_errors == 0 && i_dut.u_intr_ctrl.i_sva.n_fail == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
